// File: i650_pkg.sv
package i650_pkg;

   // -------------------------------------------------------------------------
   // Drum geometry, one band of the general storage
   // -------------------------------------------------------------------------
   localparam int digits_per_word  = 12;
   localparam int words_per_sector = 10;
   localparam int sectors_per_band = 5;
   localparam int words_per_band   = 50;
   localparam int digits_per_band  = 600;

   // Bit positions of the first and last phase in phase_t
   localparam int phase_ap = 0;
   localparam int phase_dp = 3;

   // -------------------------------------------------------------------------
   // Vector types
   // -------------------------------------------------------------------------
   typedef logic [3:0]                             digit_t;
   typedef logic [$clog2(digits_per_band)-1:0]     digit_idx_t;
   typedef logic [$clog2(digits_per_word)-1:0]     slot_idx_t;
   typedef logic [$clog2(words_per_band)-1:0]      word_addr_t;
   typedef logic [3:0]                             phase_t;
   // Bit 0 is dx, bit 1 is d0 and so on up to d10 in bit 11
   typedef logic [digits_per_word-1:0]             digit_pulse_t;
   typedef logic [words_per_sector-1:0]            word_pulse_t;
   typedef logic [sectors_per_band-1:0]            sector_pulse_t;

   // -------------------------------------------------------------------------
   // Timing bus
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic d1_d5;
      logic d5_dx;
      logic d5_d10;
      logic d1_dx;
      logic d5_d9;
      logic d10_d1_d5;
   } composite_t;

   // Digit pulses qualified by the lower or upper half of the sector
   typedef struct packed {
      logic dxl;
      logic dxu;
      logic d0l;
      logic d0u;
      logic d1l;
      logic d1u;
      logic d2l;
      logic d10u;
   } gates_t;

   typedef struct packed {
      phase_t        phases;
      digit_pulse_t  digit_pulses;
      word_pulse_t   word_pulses;
      sector_pulse_t sector_pulses;
      composite_t    composite;
      gates_t        gates;
      logic          wl;
      logic          wu;
      logic          ewl;
      logic          hp;
      digit_idx_t    digit_idx;
      slot_idx_t     early_idx;
      slot_idx_t     ontime_idx;
   } timing_bus_t;

   // -------------------------------------------------------------------------
   // Drum access
   // -------------------------------------------------------------------------
   // Sign travels first at d0, then value[1] at d1 through value[10] at d10
   typedef struct packed {
      digit_t          sign;
      digit_t [1:10]   value;
   } drum_word_t;

   typedef struct packed {
      logic       write;
      word_addr_t addr;
      drum_word_t data;
   } access_req_t;

   typedef enum logic [1:0] {
      idle,
      wait_slot,
      transfer,
      hold_ack
   } access_state_t;

endpackage

// File: phase_clock.sv
`timescale 1ns/1ps

module phase_clock (
   input  logic             clk,
   input  logic             ctr_reset,
   output i650_pkg::phase_t phases,
   output logic             count_hold
);

   // -------------------------------------------------------------------------
   // Four-phase ring
   // -------------------------------------------------------------------------
   // A single one walks ap, bp, cp, dp and wraps back to ap, so one digit
   // time is four clk cycles. The counters stay frozen until the first dp
   // has gone by, which lets them start on a whole digit time
   always_ff @(posedge clk) begin
      if (ctr_reset) begin
         phases     <= i650_pkg::phase_t'(1) << i650_pkg::phase_ap;
         count_hold <= 1'b1;
      end else begin
         phases <= {phases[2:0], phases[3]};
         if (phases[i650_pkg::phase_dp]) begin
            count_hold <= 1'b0;
         end
      end
   end

   // Exactly one phase is active at any time once the ring is running
   phases_onehot: assert property (
      @(posedge clk) disable iff (ctr_reset)
      $onehot(phases)
   );

endmodule

// File: digit_timing.sv
`timescale 1ns/1ps

module digit_timing (
   input  logic                  clk,
   input  logic                  ctr_reset,
   input  logic                  count_hold,
   input  logic                  dp,
   output i650_pkg::timing_bus_t timing
);

   logic                                          step;
   i650_pkg::slot_idx_t                           digit_ctr;
   logic [$clog2(i650_pkg::words_per_sector)-1:0] word_ctr;
   logic [$clog2(i650_pkg::sectors_per_band)-1:0] sector_ctr;
   i650_pkg::digit_pulse_t                        digit_pulses;
   i650_pkg::word_pulse_t                         word_pulses;
   i650_pkg::sector_pulse_t                       sector_pulses;
   i650_pkg::composite_t                          composite;
   i650_pkg::gates_t                              gates;
   logic                                          wl;
   logic                                          wu;
   logic                                          ewl;
   logic                                          hp;
   i650_pkg::digit_idx_t                          digit_idx;
   i650_pkg::slot_idx_t                           early_idx;
   i650_pkg::slot_idx_t                           ontime_idx;

   // One step per digit time, at the end of dp
   assign step = dp && !count_hold;

   // -------------------------------------------------------------------------
   // Counters and storage indexes
   // -------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (ctr_reset) begin
         digit_ctr  <= '0;
         word_ctr   <= '0;
         sector_ctr <= '0;
         digit_idx  <= i650_pkg::digit_idx_t'(i650_pkg::digits_per_band - 1);
         early_idx  <= '0;
         ontime_idx <= i650_pkg::slot_idx_t'(i650_pkg::digits_per_word - 1);
      end else if (step) begin
         digit_idx  <= (digit_idx == i650_pkg::digits_per_band - 1) ? '0 : digit_idx + 1'b1;
         early_idx  <= (early_idx == i650_pkg::digits_per_word - 1) ? '0 : early_idx + 1'b1;
         ontime_idx <= (ontime_idx == i650_pkg::digits_per_word - 1) ? '0 : ontime_idx + 1'b1;
         if (digit_ctr == i650_pkg::digits_per_word - 1) begin
            digit_ctr <= '0;
            if (word_ctr == i650_pkg::words_per_sector - 1) begin
               word_ctr   <= '0;
               sector_ctr <= (sector_ctr == i650_pkg::sectors_per_band - 1) ? '0 :
                             sector_ctr + 1'b1;
            end else begin
               word_ctr <= word_ctr + 1'b1;
            end
         end else begin
            digit_ctr <= digit_ctr + 1'b1;
         end
      end
   end

   // -------------------------------------------------------------------------
   // Pulses
   // -------------------------------------------------------------------------
   // digit_ctr names the slot that opens at this step, 0 for dx up to 11 for d10
   always_ff @(posedge clk) begin
      if (ctr_reset) begin
         digit_pulses  <= '0;
         word_pulses   <= '0;
         sector_pulses <= '0;
         composite     <= '0;
         wl            <= 1'b0;
         wu            <= 1'b0;
         ewl           <= 1'b0;
         hp            <= 1'b0;
      end else if (step) begin
         digit_pulses <= i650_pkg::digit_pulse_t'(1) << digit_ctr;
         case (digit_ctr)
            4'd0: begin
               composite.d5_dx     <= 1'b0;
               composite.d1_dx     <= 1'b0;
               composite.d10_d1_d5 <= 1'b0;
               word_pulses <= i650_pkg::word_pulse_t'(1) << word_ctr;
               wl <= (word_ctr < i650_pkg::words_per_sector / 2);
               wu <= (word_ctr >= i650_pkg::words_per_sector / 2);
               // Sector changes only when word 0 comes round again
               if (word_ctr == '0) begin
                  sector_pulses <= i650_pkg::sector_pulse_t'(1) << sector_ctr;
               end
               hp <= (word_ctr == '0) && (sector_ctr == '0);
            end
            4'd1: hp <= 1'b0;
            4'd2: composite.d1_d5 <= 1'b1;
            4'd3: begin
               composite.d1_dx     <= 1'b1;
               composite.d10_d1_d5 <= 1'b1;
            end
            4'd5: ewl <= wu;
            4'd6: begin
               composite.d1_d5     <= 1'b0;
               composite.d10_d1_d5 <= 1'b0;
               composite.d5_dx     <= 1'b1;
               composite.d5_d10    <= 1'b1;
               composite.d5_d9     <= 1'b1;
            end
            4'd10: composite.d5_d9 <= 1'b0;
            4'd11: begin
               composite.d5_d10    <= 1'b0;
               composite.d10_d1_d5 <= 1'b1;
            end
            default: ;
         endcase
      end
   end

   // Half-sector gates
   always_comb begin
      gates.dxl  = digit_pulses[0] & wl;
      gates.dxu  = digit_pulses[0] & wu;
      gates.d0l  = digit_pulses[1] & wl;
      gates.d0u  = digit_pulses[1] & wu;
      gates.d1l  = digit_pulses[2] & wl;
      gates.d1u  = digit_pulses[2] & wu;
      gates.d2l  = digit_pulses[3] & wl;
      gates.d10u = digit_pulses[11] & wu;
   end

   always_comb begin
      // Phases are added at the top level from the clock ring
      timing.phases        = '0;
      timing.digit_pulses  = digit_pulses;
      timing.word_pulses   = word_pulses;
      timing.sector_pulses = sector_pulses;
      timing.composite     = composite;
      timing.gates         = gates;
      timing.wl            = wl;
      timing.wu            = wu;
      timing.ewl           = ewl;
      timing.hp            = hp;
      timing.digit_idx     = digit_idx;
      timing.early_idx     = early_idx;
      timing.ontime_idx    = ontime_idx;
   end

   // Each step leaves exactly one digit pulse standing
   digit_onehot: assert property (
      @(posedge clk) disable iff (ctr_reset)
      step |=> $onehot(digit_pulses)
   );

   // The home pulse marks dx of word 0 in sector 0 and nothing else
   hp_at_home: assert property (
      @(posedge clk) disable iff (ctr_reset)
      hp |-> digit_pulses[0] && word_pulses[0] && sector_pulses[0]
   );

endmodule

// File: drum_storage.sv
`timescale 1ns/1ps

module drum_storage (
   input  logic                 clk,
   input  logic                 dp,
   input  i650_pkg::digit_idx_t digit_idx,
   input  logic                 we,
   input  i650_pkg::digit_t     wdigit,
   output i650_pkg::digit_t     rdigit
);

   // -------------------------------------------------------------------------
   // General storage band
   // -------------------------------------------------------------------------
   // One digit per drum position. The band passes under a single head, so
   // only the position that the timing presents can be touched in a given
   // digit time
   i650_pkg::digit_t mem [i650_pkg::digits_per_band];

   // The band comes up blank
   initial begin
      foreach (mem[i]) begin
         mem[i] = '0;
      end
   end

   // Read and write both happen as the digit time closes at the end of dp.
   // The read returns the old contents of the position, and the new digit
   // is only seen on the next revolution
   always @(posedge clk) begin
      if (dp) begin
         if (we) begin
            mem[digit_idx] <= wdigit;
         end
         rdigit <= mem[digit_idx];
      end
   end

   // The timing wraps the position before it runs off the band
   idx_in_band: assert property (
      @(posedge clk)
      dp |-> digit_idx < i650_pkg::digits_per_band
   );

   // Only decimal digits are ever written to the drum
   write_is_decimal: assert property (
      @(posedge clk)
      (dp && we) |-> wdigit <= 4'd9
   );

endmodule

// File: drum_access.sv
`timescale 1ns/1ps

module drum_access (
   input  logic                  clk,
   input  logic                  ctr_reset,
   input  logic                  dp,
   input  i650_pkg::digit_idx_t  digit_idx,
   input  i650_pkg::digit_t      rdigit,
   input  logic                  req,
   input  i650_pkg::access_req_t areq,
   output logic                  we,
   output i650_pkg::digit_t      wdigit,
   output logic                  ack,
   output i650_pkg::drum_word_t  rdata
);

   localparam int word_bits  = $bits(i650_pkg::drum_word_t);
   localparam int digit_bits = $bits(i650_pkg::digit_t);

   i650_pkg::access_state_t state;
   i650_pkg::access_req_t   req_q;
   i650_pkg::slot_idx_t     digit_cnt;
   i650_pkg::word_addr_t    cur_addr;
   i650_pkg::digit_idx_t    slot_base;
   logic                    slot_hit;
   logic                    last_digit;

   // -------------------------------------------------------------------------
   // Slot detection
   // -------------------------------------------------------------------------
   // In idle the address comes straight from the host, so a request that
   // arrives just as its own dx passes still catches it
   assign cur_addr   = (state == i650_pkg::idle) ? areq.addr : req_q.addr;
   assign slot_base  = i650_pkg::digit_idx_t'(cur_addr * i650_pkg::digits_per_word);
   assign slot_hit   = dp && (digit_idx == slot_base);
   assign last_digit = (digit_cnt == i650_pkg::digits_per_word - 1);

   // Digit count 0 writes d0 (sign), counts 1 to 10 write d1 to d10
   assign we     = (state == i650_pkg::transfer) && req_q.write && !last_digit;
   assign wdigit = req_q.data.sign;

   // -------------------------------------------------------------------------
   // Handshake and transfer FSM
   // -------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (ctr_reset) begin
         state     <= i650_pkg::idle;
         digit_cnt <= '0;
         ack       <= 1'b0;
         rdata     <= '0;
      end else begin
         case (state)
            i650_pkg::idle: begin
               if (req) begin
                  digit_cnt <= '0;
                  if (slot_hit) begin
                     state <= i650_pkg::transfer;
                  end else begin
                     state <= i650_pkg::wait_slot;
                  end
               end
            end
            i650_pkg::wait_slot: begin
               if (slot_hit) begin
                  digit_cnt <= '0;
                  state     <= i650_pkg::transfer;
               end
            end
            i650_pkg::transfer: begin
               if (dp) begin
                  digit_cnt <= digit_cnt + 1'b1;
                  // Storage output lags one digit time, so the dx gap read
                  // arrives at count 0 and is dropped
                  if (!req_q.write && digit_cnt != '0) begin
                     rdata <= i650_pkg::drum_word_t'({rdata[word_bits-digit_bits-1:0], rdigit});
                  end
                  if (last_digit) begin
                     ack   <= 1'b1;
                     state <= i650_pkg::hold_ack;
                  end
               end
            end
            i650_pkg::hold_ack: begin
               if (!req) begin
                  ack   <= 1'b0;
                  state <= i650_pkg::idle;
               end
            end
            default: state <= i650_pkg::idle;
         endcase
      end
   end

   // Request register. The word is shifted out sign first during a write
   always_ff @(posedge clk) begin
      if (state == i650_pkg::idle && req) begin
         req_q <= areq;
      end else if (state == i650_pkg::transfer && dp) begin
         req_q.data <= i650_pkg::drum_word_t'({req_q.data[word_bits-digit_bits-1:0],
                                               i650_pkg::digit_t'(0)});
      end
   end

   // ack only ever answers a pending request
   ack_needs_req: assert property (
      @(posedge clk) disable iff (ctr_reset)
      $rose(ack) |-> req
   );

   // The host never asks for a slot beyond the band
   addr_in_band: assert property (
      @(posedge clk) disable iff (ctr_reset)
      (req && state == i650_pkg::idle) |-> areq.addr < i650_pkg::words_per_band
   );

endmodule

// File: i650_timing_top.sv
`timescale 1ns/1ps

module i650_timing_top (
   input  logic                  clk,
   input  logic                  ctr_reset,
   input  logic                  req,
   input  i650_pkg::access_req_t areq,
   output logic                  ack,
   output i650_pkg::drum_word_t  rdata,
   output i650_pkg::timing_bus_t timing
);

   i650_pkg::phase_t      phases;
   logic                  count_hold;
   logic                  dp;
   i650_pkg::timing_bus_t core_timing;
   logic                  we;
   i650_pkg::digit_t      wdigit;
   i650_pkg::digit_t      rdigit;

   assign dp = phases[i650_pkg::phase_dp];

   phase_clock u_phase_clock (
      .clk        (clk),
      .ctr_reset  (ctr_reset),
      .phases     (phases),
      .count_hold (count_hold)
   );

   digit_timing u_digit_timing (
      .clk        (clk),
      .ctr_reset  (ctr_reset),
      .count_hold (count_hold),
      .dp         (dp),
      .timing     (core_timing)
   );

   drum_storage u_drum_storage (
      .clk       (clk),
      .dp        (dp),
      .digit_idx (core_timing.digit_idx),
      .we        (we),
      .wdigit    (wdigit),
      .rdigit    (rdigit)
   );

   drum_access u_drum_access (
      .clk       (clk),
      .ctr_reset (ctr_reset),
      .dp        (dp),
      .digit_idx (core_timing.digit_idx),
      .rdigit    (rdigit),
      .req       (req),
      .areq      (areq),
      .we        (we),
      .wdigit    (wdigit),
      .ack       (ack),
      .rdata     (rdata)
   );

   // The exported bus carries the live phases from the clock ring
   always_comb begin
      timing        = core_timing;
      timing.phases = phases;
   end

endmodule

// File: tb_i650_timing.sv
`timescale 1ns/1ps

module tb_i650_timing;

   logic                  clk;
   logic                  ctr_reset;
   logic                  req;
   i650_pkg::access_req_t areq;
   logic                  ack;
   i650_pkg::drum_word_t  rdata;
   i650_pkg::timing_bus_t timing;

   logic [15:0]           lfsr_state;
   int                    m_phase;
   logic                  m_hold;
   int                    m_steps;
   logic                  model_live;
   logic                  ack_q;
   int                    hp_count;
   int                    cycle_count;
   i650_pkg::drum_word_t  shadow [i650_pkg::words_per_band];
   i650_pkg::word_addr_t  waddr [5];

   i650_timing_top uut (
      .clk       (clk),
      .ctr_reset (ctr_reset),
      .req       (req),
      .areq      (areq),
      .ack       (ack),
      .rdata     (rdata),
      .timing    (timing)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Checking and random helpers
   // ------------------------------------------------------------------------
   task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
         $display("Errors found");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic report_failure(string what);
      $display("Failure at %0t: %s", $time, what);
      $display("Errors found");
      $fatal(1, "%s", what);
   endtask

   // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit drawn
   function automatic int unsigned draw_bits(int n);
      int unsigned bits;
      logic        fb;
      bits = 0;
      for (int k = 0; k < n; k++) begin
         bits = (bits << 1) | lfsr_state[0];
         fb = lfsr_state[0] ^ lfsr_state[2] ^ lfsr_state[3] ^ lfsr_state[5];
         lfsr_state = {fb, lfsr_state[15:1]};
      end
      return bits;
   endfunction

   function automatic i650_pkg::word_addr_t draw_addr();
      return i650_pkg::word_addr_t'(draw_bits(6) % i650_pkg::words_per_band);
   endfunction

   function automatic i650_pkg::drum_word_t draw_word();
      i650_pkg::drum_word_t w;
      w.sign = i650_pkg::digit_t'(draw_bits(4) % 10);
      for (int k = 1; k <= 10; k++) begin
         w.value[k] = i650_pkg::digit_t'(draw_bits(4) % 10);
      end
      return w;
   endfunction

   // ------------------------------------------------------------------------
   // Reference timing
   // ------------------------------------------------------------------------
   // steps counts digit times since the counters were released. Slot 0 is
   // dx, slot 1 is d0 and slot 11 is d10
   function automatic i650_pkg::timing_bus_t expect_timing(int steps, int phase);
      i650_pkg::timing_bus_t t;
      int p;
      int d;
      int w;
      int s;
      t = '0;
      t.phases     = i650_pkg::phase_t'(1) << phase;
      t.digit_idx  = i650_pkg::digit_idx_t'(i650_pkg::digits_per_band - 1);
      t.ontime_idx = i650_pkg::slot_idx_t'(i650_pkg::digits_per_word - 1);
      if (steps > 0) begin
         p = (steps - 1) % i650_pkg::digits_per_band;
         d = p % 12;
         w = (p / 12) % 10;
         s = p / 120;
         t.digit_pulses  = i650_pkg::digit_pulse_t'(1) << d;
         t.word_pulses   = i650_pkg::word_pulse_t'(1) << w;
         t.sector_pulses = i650_pkg::sector_pulse_t'(1) << s;
         t.wl = (w < 5);
         t.wu = (w >= 5);
         t.hp = (p == 0);
         // ewl follows wu from d4 on, so before d4 it still shows the last word
         if (d >= 5) begin
            t.ewl = t.wu;
         end else if (steps > 12) begin
            t.ewl = ((w + 9) % 10) >= 5;
         end
         t.composite.d1_d5     = (d >= 2 && d <= 5);
         t.composite.d5_dx     = (d >= 6);
         t.composite.d5_d10    = (d >= 6 && d <= 10);
         t.composite.d1_dx     = (d >= 3);
         t.composite.d5_d9     = (d >= 6 && d <= 9);
         t.composite.d10_d1_d5 = (d >= 3 && d <= 5) || (d == 11);
         t.gates.dxl  = (d == 0) && t.wl;
         t.gates.dxu  = (d == 0) && t.wu;
         t.gates.d0l  = (d == 1) && t.wl;
         t.gates.d0u  = (d == 1) && t.wu;
         t.gates.d1l  = (d == 2) && t.wl;
         t.gates.d1u  = (d == 2) && t.wu;
         t.gates.d2l  = (d == 3) && t.wl;
         t.gates.d10u = (d == 11) && t.wu;
         t.digit_idx  = i650_pkg::digit_idx_t'(p);
         t.ontime_idx = i650_pkg::slot_idx_t'(d);
         t.early_idx  = i650_pkg::slot_idx_t'((d + 1) % 12);
      end
      return t;
   endfunction

   // Model of the phase ring and the counter hold, stepped on the clock edge
   always @(posedge clk) begin
      if (ctr_reset) begin
         m_phase    = 0;
         m_hold     = 1'b1;
         m_steps    = 0;
         model_live = 1'b1;
      end else if (model_live) begin
         if (m_phase == 3 && !m_hold) begin
            m_steps = m_steps + 1;
         end
         if (m_phase == 3) begin
            m_hold = 1'b0;
         end
         m_phase = (m_phase + 1) % 4;
      end
   end

   // Compare the timing bus half a cycle after each edge
   always @(negedge clk) begin : compare
      i650_pkg::timing_bus_t exp_t;
      if (model_live) begin
         exp_t = expect_timing(m_steps, m_phase);
         check_value("phases", timing.phases, exp_t.phases);
         check_value("digit_pulses", timing.digit_pulses, exp_t.digit_pulses);
         check_value("word_pulses", timing.word_pulses, exp_t.word_pulses);
         check_value("sector_pulses", timing.sector_pulses, exp_t.sector_pulses);
         check_value("composite", timing.composite, exp_t.composite);
         check_value("gates", timing.gates, exp_t.gates);
         check_value("wl wu ewl hp", {timing.wl, timing.wu, timing.ewl, timing.hp},
                     {exp_t.wl, exp_t.wu, exp_t.ewl, exp_t.hp});
         check_value("digit_idx", timing.digit_idx, exp_t.digit_idx);
         check_value("early_idx", timing.early_idx, exp_t.early_idx);
         check_value("ontime_idx", timing.ontime_idx, exp_t.ontime_idx);
         if (ack && !ack_q && !req) begin
            report_failure("ack rose while req was low");
         end
         ack_q = ack;
         if (m_phase == 3 && m_steps >= 1 && m_steps <= 600 && timing.hp) begin
            hp_count = hp_count + 1;
         end
      end
   end

   // Limit is 12 accesses of at most 2448 cycles plus one revolution, with margin
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= 40000) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_count);
         $display("Errors found");
         $fatal(1, "run timed out");
      end
   end

   // ------------------------------------------------------------------------
   // Host side of the req/ack handshake
   // ------------------------------------------------------------------------
   task automatic run_access(input logic write, input i650_pkg::word_addr_t addr,
                             input i650_pkg::drum_word_t data);
      i650_pkg::access_req_t r;
      int latency;
      int hold;
      int waited;
      r.write = write;
      r.addr  = addr;
      r.data  = data;
      @(posedge clk);
      req  <= 1'b1;
      areq <= r;
      // Latency counts from the edge that first samples req
      @(posedge clk);
      latency = 0;
      @(negedge clk);
      while (!ack) begin
         latency = latency + 1;
         @(negedge clk);
      end
      if (latency < 4 * i650_pkg::digits_per_word ||
          latency > 4 * (i650_pkg::digits_per_band + i650_pkg::digits_per_word)) begin
         report_failure($sformatf("ack latency of %0d cycles is out of range", latency));
      end
      if (write) begin
         shadow[addr] = data;
      end else begin
         check_value("rdata", rdata, shadow[addr]);
      end
      hold = draw_bits(4);
      repeat (hold) begin
         @(negedge clk);
         check_value("ack", ack, 1'b1);
      end
      @(posedge clk);
      req <= 1'b0;
      waited = 0;
      @(negedge clk);
      while (ack) begin
         waited = waited + 1;
         if (waited > 4) begin
            report_failure("ack stayed high after req was dropped");
         end
         @(negedge clk);
      end
   endtask

   initial begin
      i650_pkg::word_addr_t addr;
      i650_pkg::drum_word_t word;
      logic                 wr;
      lfsr_state  = 16'd72;
      ctr_reset   = 1'b1;
      req         = 1'b0;
      areq        = '0;
      model_live  = 1'b0;
      ack_q       = 1'b0;
      hp_count    = 0;
      cycle_count = 0;
      foreach (shadow[k]) begin
         shadow[k] = '0;
      end
      repeat (2) @(posedge clk);
      ctr_reset <= 1'b0;

      // Nothing written yet, so this word comes back blank
      addr = draw_addr();
      run_access(1'b0, addr, '0);
      for (int i = 0; i < 5; i++) begin
         waddr[i] = draw_addr();
         word = draw_word();
         run_access(1'b1, waddr[i], word);
      end
      for (int i = 0; i < 5; i++) begin
         run_access(1'b0, waddr[i], '0);
      end
      wr   = draw_bits(1);
      addr = draw_addr();
      word = draw_word();
      run_access(wr, addr, word);

      // Let the timing sweep cover a whole revolution
      while (m_steps <= i650_pkg::digits_per_band) begin
         @(negedge clk);
      end
      if (hp_count == 1) begin
         $display("No errors");
         $finish;
      end else begin
         $display("Fail at %0t: hp count is %0d, expected 1", $time, hp_count);
         $display("Errors found");
         $fatal(1, "hp count wrong");
      end
   end

endmodule

// File: list.f
i650_pkg.sv
phase_clock.sv
digit_timing.sv
drum_storage.sv
drum_access.sv
i650_timing_top.sv
tb_i650_timing.sv
